//--- Bender.yml
package:
  name: lsu_subsys

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/lsu_fifo.sv
      - source/lsu_buf.sv
      - source/tl_ram.sv
      - source/lsu_resp_buf.sv
      - source/lsu_subsys.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_lsu_subsys.sv

//--- filelist.f
+incdir+source
source/lsu_pkg.sv
source/lsu_fifo.sv
source/lsu_buf.sv
source/tl_ram.sv
source/lsu_resp_buf.sv
source/lsu_subsys.sv
test/tb_lsu_subsys.sv

//--- source/lsu_buf.sv
// load/store request buffer

`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module lsu_buf
    import lsu_pkg::*;
#(
    parameter int NUM_BUF = `LSU_NUM_BUF
) (
    input  wire                          core_clk,
    input  wire                          rst_n,
    input  wire                          lspipe_a_valid,
    output logic                         lspipe_a_ready,
    input  wire tl_a_chan_t              lspipe_a,
    output logic                         lsbuf_a_valid,
    input  wire                          lsbuf_a_ready,
    output tl_a_chan_t                   lsbuf_a,
    input  wire                          release_valid,
    input  wire [`LSU_SOURCE_WIDTH-1:0]  release_source
);

    localparam int NUM_SRC = 1 << `LSU_SOURCE_WIDTH;

    logic [NUM_SRC-1:0] busy;
    logic               src_busy;
    logic               q_valid;
    logic               q_ready;
    logic               accept;

    // a request waits upstream until its id has been answered
    assign src_busy       = busy[lspipe_a.source];
    assign q_valid        = lspipe_a_valid && !src_busy;
    assign lspipe_a_ready = q_ready && !src_busy;
    assign accept         = lspipe_a_valid && lspipe_a_ready;

    generate
        if (NUM_BUF == 0) begin : gen_lsu_bypass
            assign lsbuf_a_valid = q_valid;
            assign lsbuf_a       = lspipe_a;
            assign q_ready       = lsbuf_a_ready;
        end else begin : gen_lsu_buf
            lsu_fifo #(
                .DEPTH (NUM_BUF),
                .T     (tl_a_chan_t)
            ) a_fifo_i (
                .core_clk  (core_clk),
                .rst_n     (rst_n),
                .in_valid  (q_valid),
                .in_ready  (q_ready),
                .in_data   (lspipe_a),
                .out_valid (lsbuf_a_valid),
                .out_ready (lsbuf_a_ready),
                .out_data  (lsbuf_a)
            );
        end
    endgenerate

    // ##################################################
    // outstanding source ids
    // ##################################################

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (release_valid) begin
                busy[release_source] <= 1'b0;
            end
            if (accept) begin
                busy[lspipe_a.source] <= 1'b1;
            end
        end
    end

    // every response seen at the top level belongs to an accepted request
    a_release_busy: assert property (
        @(posedge core_clk) disable iff (!rst_n)
        release_valid |-> busy[release_source]
    );

endmodule

`default_nettype wire

//--- source/lsu_config.svh
// lsu subsystem configuration

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ##################################################
// channel widths
// ##################################################

// byte address
`define LSU_ADDR_WIDTH 32

// one beat, mask carries one bit per byte
`define LSU_DATA_WIDTH 32

// four ids can be in flight
`define LSU_SOURCE_WIDTH 2

// ##################################################
// buffering and memory
// ##################################################

// a-channel queue depth, 0 selects bypass
`define LSU_NUM_BUF 4

// ram size in words, byte addresses from 1024 up are out of range
`define LSU_RAM_WORDS 256

`endif

//--- source/lsu_fifo.sv
// valid/ready fifo

`timescale 1ns/1ps
`default_nettype none

module lsu_fifo #(
    parameter int  DEPTH = 2,
    parameter type T     = logic
) (
    input  wire  core_clk,
    input  wire  rst_n,
    input  wire  in_valid,
    output logic in_ready,
    input  wire  T in_data,
    output logic out_valid,
    input  wire  out_ready,
    output T     out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W+1)'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write pointer runs count entries ahead of the read pointer,
    // so a write never lands on an entry still waiting to be read
    a_no_write_full: assert property (
        @(posedge core_clk) disable iff (!rst_n)
        (count <= FULL_CNT) && (((int'(rd_ptr) + int'(count)) % DEPTH) == int'(wr_ptr))
    );

endmodule

`default_nettype wire

//--- source/lsu_pkg.sv
// lsu channel types

`include "lsu_config.svh"
`default_nettype none

package lsu_pkg;

    // ##################################################
    // opcodes
    // ##################################################

    // tilelink a-channel encodings
    typedef enum logic [2:0] {
        PUT_FULL    = 3'd0,
        PUT_PARTIAL = 3'd1,
        ARITH       = 3'd2,
        LOGICAL     = 3'd3,
        GET         = 3'd4,
        INTENT      = 3'd5
    } tl_a_op_e;

    typedef enum logic [2:0] {
        ACCESS_ACK      = 3'd0,
        ACCESS_ACK_DATA = 3'd1
    } tl_d_op_e;

    // ##################################################
    // channel payloads
    // ##################################################

    // size is log2 of bytes, single beat so at most 2
    typedef struct packed {
        tl_a_op_e                         opcode;
        logic [1:0]                       size;
        logic [`LSU_SOURCE_WIDTH-1:0]     source;
        logic [`LSU_ADDR_WIDTH-1:0]       address;
        logic [`LSU_DATA_WIDTH-1:0]       data;
        logic [`LSU_DATA_WIDTH/8-1:0]     mask;
        logic                             corrupt;
    } tl_a_chan_t;

    typedef struct packed {
        tl_d_op_e                         opcode;
        logic [1:0]                       size;
        logic [`LSU_SOURCE_WIDTH-1:0]     source;
        logic [`LSU_DATA_WIDTH-1:0]       data;
        logic                             denied;
        logic                             corrupt;
    } tl_d_chan_t;

endpackage

`default_nettype wire

//--- source/lsu_resp_buf.sv
// response buffer

`timescale 1ns/1ps
`default_nettype none

module lsu_resp_buf
    import lsu_pkg::*;
(
    input  wire             core_clk,
    input  wire             rst_n,
    input  wire             in_valid,
    output logic            in_ready,
    input  wire tl_d_chan_t in,
    output logic            out_valid,
    input  wire             out_ready,
    output tl_d_chan_t      out
);

    // two entries keep the ram streaming while the consumer stalls briefly
    lsu_fifo #(
        .DEPTH (2),
        .T     (tl_d_chan_t)
    ) d_fifo_i (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out)
    );

    // data-carrying denial from the slave must flag its data as unusable
    a_denied_corrupt: assert property (
        @(posedge core_clk) disable iff (!rst_n)
        in_valid && in.denied && (in.opcode == ACCESS_ACK_DATA) |-> in.corrupt
    );

endmodule

`default_nettype wire

//--- source/lsu_subsys.sv
// load/store subsystem top

`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module lsu_subsys
    import lsu_pkg::*;
(
    input  wire             core_clk,
    input  wire             rst_n,
    input  wire             a_valid,
    output logic            a_ready,
    input  wire tl_a_chan_t a,
    output logic            d_valid,
    input  wire             d_ready,
    output tl_d_chan_t      d
);

    logic       buf_a_valid;
    logic       buf_a_ready;
    tl_a_chan_t buf_a;
    logic       ram_d_valid;
    logic       ram_d_ready;
    tl_d_chan_t ram_d;
    logic       release_valid;

    // an id frees up once its response leaves the subsystem
    assign release_valid = d_valid && d_ready;

    lsu_buf #(
        .NUM_BUF (`LSU_NUM_BUF)
    ) lsu_buf_i (
        .core_clk       (core_clk),
        .rst_n          (rst_n),
        .lspipe_a_valid (a_valid),
        .lspipe_a_ready (a_ready),
        .lspipe_a       (a),
        .lsbuf_a_valid  (buf_a_valid),
        .lsbuf_a_ready  (buf_a_ready),
        .lsbuf_a        (buf_a),
        .release_valid  (release_valid),
        .release_source (d.source)
    );

    tl_ram tl_ram_i (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .a_valid  (buf_a_valid),
        .a_ready  (buf_a_ready),
        .a        (buf_a),
        .d_valid  (ram_d_valid),
        .d_ready  (ram_d_ready),
        .d        (ram_d)
    );

    lsu_resp_buf lsu_resp_buf_i (
        .core_clk  (core_clk),
        .rst_n     (rst_n),
        .in_valid  (ram_d_valid),
        .in_ready  (ram_d_ready),
        .in        (ram_d),
        .out_valid (d_valid),
        .out_ready (d_ready),
        .out       (d)
    );

endmodule

`default_nettype wire

//--- source/tl_ram.sv
// tilelink ram slave

`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module tl_ram
    import lsu_pkg::*;
(
    input  wire             core_clk,
    input  wire             rst_n,
    input  wire             a_valid,
    output logic            a_ready,
    input  wire tl_a_chan_t a,
    output logic            d_valid,
    input  wire             d_ready,
    output tl_d_chan_t      d
);

    localparam int NUM_BYTES = `LSU_DATA_WIDTH / 8;
    localparam int OFF_W     = $clog2(NUM_BYTES);
    localparam int WORD_AW   = $clog2(`LSU_RAM_WORDS);
    localparam logic [`LSU_ADDR_WIDTH-1:0] RAM_BYTES =
        `LSU_ADDR_WIDTH'(`LSU_RAM_WORDS * NUM_BYTES);

    logic [`LSU_DATA_WIDTH-1:0] mem [`LSU_RAM_WORDS];

    logic                 accept;
    logic                 in_range;
    logic                 is_put;
    logic                 is_get;
    logic                 wants_data;
    logic                 ok;
    logic                 do_write;
    logic [WORD_AW-1:0]   word_addr;
    logic [NUM_BYTES-1:0] wr_mask;
    tl_d_chan_t           d_next;

    // one response register, refilled in the cycle it drains
    assign a_ready = !d_valid || d_ready;
    assign accept  = a_valid && a_ready;

    // ##################################################
    // request decode
    // ##################################################

    assign word_addr  = a.address[OFF_W +: WORD_AW];
    assign in_range   = (a.address < RAM_BYTES);
    assign is_put     = (a.opcode == PUT_FULL) || (a.opcode == PUT_PARTIAL);
    assign is_get     = (a.opcode == GET);
    // arithmetic and logical atomics would return data too
    assign wants_data = a.opcode inside {GET, ARITH, LOGICAL};
    assign ok         = in_range && (is_put || is_get);
    assign wr_mask    = (a.opcode == PUT_FULL) ? '1 : a.mask;
    assign do_write   = accept && ok && is_put;

    // ##################################################
    // storage
    // ##################################################

    always_ff @(posedge core_clk) begin
        if (do_write) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (wr_mask[i]) begin
                    mem[word_addr][8*i +: 8] <= a.data[8*i +: 8];
                end
            end
        end
    end

    // ##################################################
    // response
    // ##################################################

    always_comb begin
        d_next.opcode  = wants_data ? ACCESS_ACK_DATA : ACCESS_ACK;
        d_next.size    = a.size;
        d_next.source  = a.source;
        d_next.denied  = !ok;
        // a denied read has no valid data to return
        d_next.corrupt = !ok && wants_data;
        d_next.data    = (ok && is_get) ? mem[word_addr] : '0;
    end

    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (accept) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            d <= d_next;
        end
    end

    // upstream buffer must hold a stalled request unchanged
    a_req_stable: assert property (
        @(posedge core_clk) disable iff (!rst_n)
        a_valid && !a_ready |=> a_valid && $stable(a)
    );

endmodule

`default_nettype wire

//--- test/tb_lsu_subsys.sv
// lsu subsystem testbench

`timescale 1ns/1ps
`include "lsu_config.svh"
`default_nettype none

module tb_lsu_subsys
    import lsu_pkg::*;
();

    localparam int TIMEOUT  = 200;
    localparam int NUM_ROWS = 16;

    typedef struct packed {
        tl_a_op_e                     op;
        logic [`LSU_ADDR_WIDTH-1:0]   addr;
        logic [`LSU_DATA_WIDTH/8-1:0] mask;
        logic [`LSU_DATA_WIDTH-1:0]   data;
        logic [`LSU_SOURCE_WIDTH-1:0] src;
        logic [1:0]                   size;
        tl_d_op_e                     exp_op;
        logic                         exp_denied;
    } stim_row_t;

    logic        core_clk;
    logic        rst_n;
    logic        a_valid;
    logic        a_ready;
    tl_a_chan_t  a;
    logic        d_valid;
    logic        d_ready;
    tl_d_chan_t  d;
    logic        random_ready;
    integer      seed;
    logic [31:0] rnd;
    logic [7:0]  ref_mem [4*`LSU_RAM_WORDS];
    tl_d_chan_t  exp_q [$];
    stim_row_t   lat_row;

    // ##################################################
    // stimulus table
    // ##################################################

    // 0x410 aliases word 0x010 inside the ram, so a leaked denied write would show up
    stim_row_t rows [NUM_ROWS] = '{
        '{PUT_FULL,    32'h010, 4'hf,    32'ha1b2c3d4, 2'd0, 2'd2, ACCESS_ACK,      1'b0},
        '{GET,         32'h010, 4'hf,    32'h00000000, 2'd1, 2'd2, ACCESS_ACK_DATA, 1'b0},
        '{PUT_FULL,    32'h020, 4'hf,    32'h11223344, 2'd2, 2'd2, ACCESS_ACK,      1'b0},
        '{PUT_PARTIAL, 32'h020, 4'b0101, 32'haabbccdd, 2'd3, 2'd2, ACCESS_ACK,      1'b0},
        '{GET,         32'h020, 4'hf,    32'h00000000, 2'd0, 2'd2, ACCESS_ACK_DATA, 1'b0},
        '{GET,         32'h400, 4'hf,    32'h00000000, 2'd1, 2'd2, ACCESS_ACK_DATA, 1'b1},
        '{PUT_FULL,    32'h410, 4'hf,    32'hdeadbeef, 2'd2, 2'd2, ACCESS_ACK,      1'b1},
        '{ARITH,       32'h010, 4'hf,    32'h00000001, 2'd3, 2'd2, ACCESS_ACK_DATA, 1'b1},
        '{LOGICAL,     32'h020, 4'hf,    32'hffffffff, 2'd3, 2'd1, ACCESS_ACK_DATA, 1'b1},
        '{INTENT,      32'h010, 4'hf,    32'h00000000, 2'd3, 2'd0, ACCESS_ACK,      1'b1},
        '{GET,         32'h010, 4'hf,    32'h00000000, 2'd3, 2'd2, ACCESS_ACK_DATA, 1'b0},
        '{GET,         32'h020, 4'hf,    32'h00000000, 2'd3, 2'd2, ACCESS_ACK_DATA, 1'b0},
        '{PUT_FULL,    32'h3fc, 4'hf,    32'h0badf00d, 2'd0, 2'd2, ACCESS_ACK,      1'b0},
        '{GET,         32'h3fc, 4'hf,    32'h00000000, 2'd0, 2'd2, ACCESS_ACK_DATA, 1'b0},
        '{PUT_PARTIAL, 32'h3fc, 4'b1010, 32'h55667788, 2'd1, 2'd1, ACCESS_ACK,      1'b0},
        '{GET,         32'h3fc, 4'hf,    32'h00000000, 2'd2, 2'd2, ACCESS_ACK_DATA, 1'b0}
    };

    lsu_subsys dut_i (
        .core_clk (core_clk),
        .rst_n    (rst_n),
        .a_valid  (a_valid),
        .a_ready  (a_ready),
        .a        (a),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .d        (d)
    );

    initial begin
        core_clk = 1'b0;
        forever begin
            #10 core_clk = ~core_clk;
        end
    end

    // consumer back-pressure, about three cycles in four ready
    always @(posedge core_clk) begin
        #2;
        rnd     = $random(seed);
        d_ready = random_ready ? (rnd[1:0] != 2'b00) : 1'b1;
    end

    // ##################################################
    // helpers
    // ##################################################

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_timeout(input int waited, input string what);
        assert (waited < TIMEOUT) else begin
            $display("timed out after %0d cycles waiting for %s", waited, what);
            stop_run();
        end
    endtask

    // expected response, and the ram image after the request
    task automatic record_expected(input stim_row_t row);
        tl_d_chan_t resp;
        int         base;
        resp         = '0;
        resp.opcode  = row.exp_op;
        resp.size    = row.size;
        resp.source  = row.src;
        resp.denied  = row.exp_denied;
        resp.corrupt = row.exp_denied && (row.exp_op == ACCESS_ACK_DATA);
        base         = int'(row.addr) & ~3;
        if (!row.exp_denied) begin
            for (int i = 0; i < 4; i++) begin
                if (row.op == GET) begin
                    resp.data[8*i +: 8] = ref_mem[base+i];
                end else if (row.op == PUT_FULL || row.mask[i]) begin
                    ref_mem[base+i] = row.data[8*i +: 8];
                end
            end
        end
        exp_q.push_back(resp);
    endtask

    task automatic send_row(input stim_row_t row);
        int waited;
        waited    = 0;
        a         = '0;
        a.opcode  = row.op;
        a.size    = row.size;
        a.source  = row.src;
        a.address = row.addr;
        a.data    = row.data;
        a.mask    = row.mask;
        a_valid   = 1'b1;
        @(negedge core_clk);
        while (!a_ready) begin
            waited++;
            check_timeout(waited, "a_ready");
            @(negedge core_clk);
        end
        // transfer on the coming rising edge
        record_expected(row);
        @(posedge core_clk);
        #2;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge core_clk);
            waited++;
            check_timeout(waited, "outstanding responses");
        end
    endtask

    // ##################################################
    // response checker
    // ##################################################

    initial begin : resp_check
        tl_d_chan_t resp;
        forever begin
            @(negedge core_clk);
            if (rst_n && d_valid && d_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("a response arrived with no request outstanding");
                    stop_run();
                end
                resp = exp_q.pop_front();
                check_value("d.opcode", 32'(d.opcode), 32'(resp.opcode));
                check_value("d.denied", 32'(d.denied), 32'(resp.denied));
                check_value("d.corrupt", 32'(d.corrupt), 32'(resp.corrupt));
                check_value("d.source", 32'(d.source), 32'(resp.source));
                check_value("d.size", 32'(d.size), 32'(resp.size));
                if (resp.opcode == ACCESS_ACK_DATA) begin
                    check_value("d.data", d.data, resp.data);
                end
            end
        end
    end

    // ##################################################
    // main sequence
    // ##################################################

    initial begin
        int lat;
        seed         = 32'hd7e8949b;
        rst_n        = 1'b0;
        a_valid      = 1'b0;
        a            = '0;
        d_ready      = 1'b0;
        random_ready = 1'b1;
        for (int i = 0; i < 4*`LSU_RAM_WORDS; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (5) @(posedge core_clk);
        #2;
        rst_n = 1'b1;

        @(negedge core_clk);
        check_value("d_valid", 32'(d_valid), 32'd0);
        check_value("a_ready", 32'(a_ready), 32'd1);
        @(posedge core_clk);
        #2;

        // rows go back to back, a_valid stays high between them
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_row(rows[i]);
        end
        a_valid = 1'b0;
        wait_drain();

        // lone read on an idle subsystem with d_ready held high
        random_ready = 1'b0;
        repeat (2) @(posedge core_clk);
        #2;
        lat_row = '{GET, 32'h010, 4'hf, 32'h0, 2'd1, 2'd2, ACCESS_ACK_DATA, 1'b0};
        send_row(lat_row);
        a_valid = 1'b0;
        lat     = 0;
        do begin
            @(negedge core_clk);
            lat++;
            check_timeout(lat, "d_valid");
        end while (!d_valid);
        // counted in cycles from the handshake cycle
        check_value("d_valid latency", 32'(lat), 32'd3);
        wait_drain();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
